// File: Bender.yml
package:
  name: node_sorter

export_include_dirs:
  - .

sources:
  # package first, then the merge levels and the top level
  - files:
      - hdl/sortPkg.sv
      - hdl/runMerge.sv
      - hdl/mergeLevel.sv
      - hdl/nodeSorter.sv

  # testbench only
  - target: test
    include_dirs:
      - .
    files:
      - testbench/nodeSorterTb.sv

// File: hdl/mergeLevel.sv
// one registered merge stage, turns sorted runs of RUN_LEN into sorted runs of 2*RUN_LEN
`timescale 1ns/1ps
`include "sorter_defs.svh"

module mergeLevel #(
  parameter int RUN_LEN = 1
) (
  input  logic                clk,
  input  logic                rst,
  input  sortPkg::nodeStream_t inStream,
  output logic                inReady,
  output sortPkg::nodeStream_t outStream,
  input  logic                outReady
);

  // nodes covered by one merge, and how many merges fit in a vector
  localparam int SPAN  = 2 * RUN_LEN;
  localparam int PAIRS = `SORT_NODES / SPAN;

  // merged vector before the output register
  wire sortPkg::nodeVec_t mergedNodes;

  // output register
  logic              validQ;
  sortPkg::nodeVec_t nodesQ;

  // ##############################
  // run pair merges
  // ##############################

  // pair p covers positions p*SPAN up to p*SPAN+SPAN-1
  // left run is the first half, right run the second half
  for (genvar p = 0; p < PAIRS; p++) begin : genPair
    runMerge #(
      .RUN_LEN (RUN_LEN)
    ) pairMerge (
      .leftRun   (inStream.nodes[p*SPAN +: RUN_LEN]),
      .rightRun  (inStream.nodes[p*SPAN+RUN_LEN +: RUN_LEN]),
      .mergedRun (mergedNodes[p*SPAN +: SPAN])
    );
  end

  // ##############################
  // handshake
  // ##############################

  // free to take a vector when empty or when the current one leaves this cycle
  assign inReady = !validQ || outReady;

  // valid bit is the only control state of the stage
  always_ff @(posedge clk) begin
    if (rst) begin
      validQ <= 1'b0;
    end else if (inReady) begin
      validQ <= inStream.valid;
    end
  end

  // payload only moves on a real transfer, so it holds while stalled
  always_ff @(posedge clk) begin
    if (inReady && inStream.valid) begin
      nodesQ <= mergedNodes;
    end
  end

  // ##############################
  // output stream
  // ##############################

  assign outStream.valid = validQ;
  assign outStream.nodes = nodesQ;

endmodule

// File: hdl/nodeSorter.sv
// top of the eight-node weight sorter, three pipelined merge levels behind a valid/ready stream
`timescale 1ns/1ps

module nodeSorter (
  input  logic              clk,
  input  logic              rst,
  input  logic              inValid,
  output logic              inReady,
  input  sortPkg::nodeVec_t inNodes,
  output logic              outValid,
  input  logic              outReady,
  output sortPkg::nodeVec_t outNodes
);

  // streams between the levels
  sortPkg::nodeStream_t pairsIn;
  sortPkg::nodeStream_t pairsOut;
  sortPkg::nodeStream_t quadsOut;
  sortPkg::nodeStream_t fullOut;

  // ready from each later level back to the one before
  logic quadsReady;
  logic fullReady;

  // ##############################
  // input side
  // ##############################

  assign pairsIn.valid = inValid;
  assign pairsIn.nodes = inNodes;

  // ##############################
  // merge chain
  // ##############################

  // level 1, compare-exchange of neighbours
  mergeLevel #(
    .RUN_LEN (1)
  ) levelPairs (
    .clk       (clk),
    .rst       (rst),
    .inStream  (pairsIn),
    .inReady   (inReady),
    .outStream (pairsOut),
    .outReady  (quadsReady)
  );

  // level 2, sorted pairs into sorted runs of four
  mergeLevel #(
    .RUN_LEN (2)
  ) levelQuads (
    .clk       (clk),
    .rst       (rst),
    .inStream  (pairsOut),
    .inReady   (quadsReady),
    .outStream (quadsOut),
    .outReady  (fullReady)
  );

  // level 3, two runs of four into the full order
  mergeLevel #(
    .RUN_LEN (4)
  ) levelFull (
    .clk       (clk),
    .rst       (rst),
    .inStream  (quadsOut),
    .inReady   (fullReady),
    .outStream (fullOut),
    .outReady  (outReady)
  );

  // ##############################
  // output side
  // ##############################

  assign outValid = fullOut.valid;
  assign outNodes = fullOut.nodes;

endmodule

// File: hdl/runMerge.sv
// combinational merge of two weight-sorted runs, one instance per run pair in a merge level
`timescale 1ns/1ps

module runMerge #(
  parameter int RUN_LEN = 1
) (
  input  sortPkg::node_t [0:RUN_LEN-1]   leftRun,
  input  sortPkg::node_t [0:RUN_LEN-1]   rightRun,
  output sortPkg::node_t [0:2*RUN_LEN-1] mergedRun
);

  // cursor must reach RUN_LEN itself to flag an exhausted run
  localparam int CUR_W = $clog2(RUN_LEN) + 1;

  // one output slot per pass, RUN_LEN taken from each side in total
  localparam int OUT_LEN = 2 * RUN_LEN;

  // ##############################
  // two-cursor insertion
  // ##############################

  // leftIdx and rightIdx point at the current head of each run
  always_comb begin : mergeLoop
    logic [CUR_W-1:0] leftIdx;
    logic [CUR_W-1:0] rightIdx;

    leftIdx  = '0;
    rightIdx = '0;

    for (int slot = 0; slot < OUT_LEN; slot++) begin
      if (leftIdx == CUR_W'(RUN_LEN)) begin
        // left side used up, drain the right run
        mergedRun[slot] = rightRun[rightIdx];
        rightIdx        = rightIdx + 1'b1;
      end else if (rightIdx == CUR_W'(RUN_LEN)) begin
        // right side used up, drain the left run
        mergedRun[slot] = leftRun[leftIdx];
        leftIdx         = leftIdx + 1'b1;
      end else if (rightRun[rightIdx].weight > leftRun[leftIdx].weight) begin
        // right head strictly heavier
        mergedRun[slot] = rightRun[rightIdx];
        rightIdx        = rightIdx + 1'b1;
      end else begin
        // equal weights stay with the left run so earlier input stays earlier
        mergedRun[slot] = leftRun[leftIdx];
        leftIdx         = leftIdx + 1'b1;
      end
    end
  end

endmodule

// File: hdl/sortPkg.sv
// node and stream types shared by every stage of the sorter, referenced by scoped names
`include "sorter_defs.svh"

package sortPkg;

  // ##############################
  // single node
  // ##############################

  // character sits in the upper bits, weight in the lower bits
  typedef struct packed {
    logic [`SORT_CHAR_W-1:0]   character;
    logic [`SORT_WEIGHT_W-1:0] weight;
  } node_t;

  // ##############################
  // node vector
  // ##############################

  // ascending range so that element 0 is the most significant slice
  // and the first position of the vector
  typedef node_t [0:`SORT_NODES-1] nodeVec_t;

  // ##############################
  // stage boundary
  // ##############################

  // valid and payload travel forward together
  // ready runs back on a separate wire
  typedef struct packed {
    logic     valid;
    nodeVec_t nodes;
  } nodeStream_t;

endpackage

// File: nodeSorter.f
+incdir+.
hdl/sortPkg.sv
hdl/runMerge.sv
hdl/mergeLevel.sv
hdl/nodeSorter.sv
testbench/nodeSorterTb.sv

// File: sorter_defs.svh
// sorter sizes, included by the package and by any RTL file that needs the node count
`ifndef SORTER_DEFS_SVH
`define SORTER_DEFS_SVH

// ##############################
// vector shape
// ##############################

// nodes in one vector, must be a power of two
`define SORT_NODES 8

// merge levels needed for SORT_NODES, log2 of the node count
`define SORT_LEVELS 3

// ##############################
// node fields
// ##############################

// character code carried along with its weight
`define SORT_CHAR_W 4

// weight used as the sort key
`define SORT_WEIGHT_W 5

`endif

// File: testbench/nodeSorterTb.sv
// testbench for the node sorter, replays the sort trace with random gaps and stalls
`timescale 1ns/1ps
`include "sorter_defs.svh"

module nodeSorterTb;

  // vectors in the trace, each line holds inputs then expected nodes
  localparam int ENTRIES = 36;
  localparam int WORDS_PER_ENTRY = 2 * `SORT_NODES;
  localparam int TRACE_WORDS = ENTRIES * WORDS_PER_ENTRY;

  // first entries go back to back with outReady held high
  localparam int BURST = 8;
  localparam int RESET_CYCLES = 3;
  localparam int MAX_CYCLES = (ENTRIES + `SORT_LEVELS) * 8;
  localparam int SEED = 59448;

  // DUT ports
  logic              clk;
  logic              rst;
  logic              inValid;
  logic              inReady;
  sortPkg::nodeVec_t inNodes;
  logic              outValid;
  logic              outReady;
  sortPkg::nodeVec_t outNodes;

  // trace contents
  logic [8:0]        traceMem [0:TRACE_WORDS-1];
  sortPkg::nodeVec_t stimVec [0:ENTRIES-1];
  sortPkg::nodeVec_t expVec [0:ENTRIES-1];

  // vectors inside the pipeline, oldest first
  sortPkg::nodeVec_t expQueue[$];
  int                acceptQueue[$];

  // bookkeeping owned by the handshake monitor
  int                cycleCount = 0;
  int                sent = 0;
  int                received = 0;
  int                lastOutCycle = 0;
  logic              stallPending = 1'b0;
  sortPkg::nodeVec_t heldNodes;

  nodeSorter dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inNodes  (inNodes),
    .outValid (outValid),
    .outReady (outReady),
    .outNodes (outNodes)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ##############################
  // helpers
  // ##############################

  task automatic stopOnFailure();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic checkValue(input string name, input logic [71:0] actual,
                            input logic [71:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
      stopOnFailure();
    end
  endtask

  // split each trace line into the input vector and the expected vector
  task automatic loadTrace();
    $readmemh("testbench/sort_trace.txt", traceMem);
    for (int w = 0; w < TRACE_WORDS; w++) begin
      if ($isunknown(traceMem[w])) begin
        $display("trace file has fewer than %0d complete entries", ENTRIES);
        stopOnFailure();
      end
    end
    for (int e = 0; e < ENTRIES; e++) begin
      for (int n = 0; n < `SORT_NODES; n++) begin
        stimVec[e][n] = traceMem[e * WORDS_PER_ENTRY + n];
        expVec[e][n]  = traceMem[e * WORDS_PER_ENTRY + `SORT_NODES + n];
      end
    end
  endtask

  // ##############################
  // handshake monitor
  // ##############################

  // runs on the rising edge, so every signal still shows the cycle before it
  always @(posedge clk) begin : handshakeMonitor
    sortPkg::nodeVec_t expected;
    int acceptedAt;

    if (!rst) begin
      cycleCount++;
      if (cycleCount > MAX_CYCLES) begin
        $display("timeout: only %0d of %0d vectors came out within %0d cycles",
                 received, ENTRIES, MAX_CYCLES);
        stopOnFailure();
      end

      // every stage full and output stalled is the only case that blocks input
      checkValue("inReady", inReady, (expQueue.size() < `SORT_LEVELS) || outReady);
      if (expQueue.size() == 0) begin
        checkValue("outValid", outValid, 1'b0);
      end

      // a stalled output has to hold its vector
      if (stallPending) begin
        checkValue("outValid", outValid, 1'b1);
        checkValue("outNodes", outNodes, heldNodes);
      end
      stallPending = outValid && !outReady;
      heldNodes    = outNodes;

      if (outValid && outReady) begin
        if (expQueue.size() == 0) begin
          $display("output vector appeared at %0t with no input vector outstanding", $time);
          stopOnFailure();
        end
        expected   = expQueue.pop_front();
        acceptedAt = acceptQueue.pop_front();
        checkValue("outNodes", outNodes, expected);
        // burst phase, fixed latency and one output per cycle
        if (received < BURST) begin
          checkValue("outValid latency", cycleCount - acceptedAt, `SORT_LEVELS);
          if (received > 0) begin
            checkValue("outValid spacing", cycleCount - lastOutCycle, 1);
          end
        end
        lastOutCycle = cycleCount;
        received++;
      end

      if (inValid && inReady) begin
        expQueue.push_back(expVec[sent]);
        acceptQueue.push_back(cycleCount);
        sent++;
      end
    end
  end

  // ##############################
  // stimulus
  // ##############################

  initial begin : mainFlow
    int presentedIdx;

    presentedIdx = 0;
    void'($urandom(SEED));
    $timeformat(-9, 0, " ns", 0);

    rst      = 1'b1;
    inValid  = 1'b0;
    inNodes  = '0;
    outReady = 1'b0;

    loadTrace();

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      checkValue("outValid", outValid, 1'b0);
    end
    rst = 1'b0;

    while (received < ENTRIES) begin
      // drop valid once the presented vector has been taken
      if (inValid && sent != presentedIdx) begin
        inValid = 1'b0;
      end
      if (!inValid && sent < ENTRIES) begin
        if (sent < BURST || $urandom_range(3, 0) != 0) begin
          inValid      = 1'b1;
          inNodes      = stimVec[sent];
          presentedIdx = sent;
        end
      end

      // receiver, always ready until the burst is through
      if (received < BURST) begin
        outReady = 1'b1;
      end else begin
        outReady = ($urandom_range(9, 0) < 6);
      end

      @(negedge clk);
    end

    // let the pipeline drain and show it stays empty
    inValid  = 1'b0;
    outReady = 1'b1;
    repeat (`SORT_LEVELS + 1) @(negedge clk);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: testbench/sort_trace.txt
// columns 1-8 input nodes in vector order, columns 9-16 expected nodes by descending weight
// each node is 9 bits in hex, character in bits 8:5 and weight in bits 4:0
// burst entries, sent back to back
001 022 043 064 085 0a6 0c7 0e8 0e8 0c7 0a6 085 064 043 022 001
01f 03e 05d 07c 09b 0ba 0d9 0f8 01f 03e 05d 07c 09b 0ba 0d9 0f8
000 020 040 060 080 0a0 0c0 0e0 000 020 040 060 080 0a0 0c0 0e0
01f 03f 05f 07f 09f 0bf 0df 0ff 01f 03f 05f 07f 09f 0bf 0df 0ff
005 031 042 07e 08b 0a0 0d7 0e9 07e 0d7 031 08b 0e9 005 042 0a0
00c 023 059 068 093 0bf 0c1 0ee 0bf 059 093 0ee 00c 068 023 0c1
014 035 046 067 09c 0bb 0cd 0e4 09c 0bb 035 014 0cd 067 046 0e4
000 03f 050 06f 088 0b8 0c2 0fd 03f 0fd 0b8 050 06f 088 0c2 000
// distinct weights, mixed characters
1e3 1c9 1a1 196 16e 147 132 11a 11a 196 132 16e 1c9 147 1e3 1a1
14a 079 184 013 1fe 0ad 120 0c7 1fe 079 013 0ad 14a 0c7 184 120
// repeated weights
005 025 043 063 087 0a7 0c1 0e1 087 0a7 005 025 043 063 0c1 0e1
001 022 041 062 081 0a2 0c1 0e2 022 062 0a2 0e2 001 041 081 0c1
000 03f 040 07f 080 0bf 0c0 0ff 03f 07f 0bf 0ff 000 040 080 0c0
01f 020 05f 060 09f 0a0 0df 0e0 01f 05f 09f 0df 020 060 0a0 0e0
0e9 0c9 0a9 089 069 049 029 009 0e9 0c9 0a9 089 069 049 029 009
004 024 044 064 094 0b4 0d4 0f4 094 0b4 0d4 0f4 004 024 044 064
00c 026 04c 066 086 0ac 0c6 0ec 00c 04c 0ac 0ec 026 066 086 0c6
0ae 0a3 04e 13b 043 1ce 01b 160 13b 01b 0ae 04e 1ce 0a3 043 160
01f 03f 040 060 09f 0bf 0c0 0e0 01f 03f 09f 0bf 040 060 0c0 0e0
010 02f 050 06f 091 0ae 0d1 0ee 091 0d1 010 050 02f 06f 0ae 0ee
// more distinct weights
102 124 146 168 18a 1ac 1ce 1f0 1f0 1ce 1ac 18a 168 146 124 102
01d 023 051 06b 09a 0a6 0d5 0e0 01d 09a 0d5 051 06b 0a6 023 0e0
008 038 040 070 084 0b4 0cc 0fc 0fc 038 0b4 070 0cc 008 084 040
073 032 091 030 0af 12e 04d 0cc 073 032 091 030 0af 12e 04d 0cc
00c 02d 04e 06f 090 0b1 0d2 0f3 0f3 0d2 0b1 090 06f 04e 02d 00c
007 03e 041 076 09a 0aa 0c3 0ef 03e 09a 076 0ef 0aa 007 0c3 041
// one node apart from a field of equal weights
002 022 042 062 082 0a2 0c2 0f9 0f9 002 022 042 062 082 0a2 0c2
00a 02a 04a 060 08a 0aa 0ca 0ea 00a 02a 04a 08a 0aa 0ca 0ea 060
// mixed ties
003 023 048 068 083 0a3 0c8 0e8 048 068 0c8 0e8 003 023 083 0a3
145 169 185 1a9 1c5 1e9 005 029 169 1a9 1e9 029 145 185 1c5 005
01f 03e 05f 07e 09f 0be 0df 0fe 01f 05f 09f 0df 03e 07e 0be 0fe
1e0 1c1 1a0 181 160 141 120 101 1c1 181 141 101 1e0 1a0 160 120
0ce 05b 0e5 013 062 0bf 029 097 0bf 05b 097 013 0ce 029 0e5 062
016 038 059 077 096 0b9 0d8 0f7 059 0b9 038 0d8 077 0f7 016 096
001 020 043 062 085 0a4 0c7 0e6 0c7 0e6 085 0a4 043 062 001 020
06b 12b 06b 1eb 00b 18b 0cb 14b 06b 12b 06b 1eb 00b 18b 0cb 14b
